/* common/cpuPkg.sv */
// Encodings shared by the 16-bit core where opcode and ALU values follow the ISA map and must not be renumbered
`default_nettype none

package cpuPkg;

    localparam int dataWidth    = 16;   // Machine word and address width
    localparam int regAddrWidth = 3;    // Index into R0..R7

    // Major opcode in bits 15..11
    typedef enum logic [4:0] {
        opHalt  = 5'b00000, opNop   = 5'b00001, opSiic  = 5'b00010, opRti   = 5'b00011,
        opJ     = 5'b00100, opJr    = 5'b00101, opJal   = 5'b00110, opJalr  = 5'b00111,
        opAddi  = 5'b01000, opSubi  = 5'b01001, opXori  = 5'b01010, opAndni = 5'b01011,
        opBeqz  = 5'b01100, opBnez  = 5'b01101, opBltz  = 5'b01110, opBgez  = 5'b01111,
        opSt    = 5'b10000, opLd    = 5'b10001, opSlbi  = 5'b10010, opStu   = 5'b10011,
        opRoli  = 5'b10100, opSlli  = 5'b10101, opRori  = 5'b10110, opSrli  = 5'b10111,
        opLbi   = 5'b11000, opBtr   = 5'b11001, opArith = 5'b11010, opShift = 5'b11011,
        opSeq   = 5'b11100, opSlt   = 5'b11101, opSle   = 5'b11110, opSco   = 5'b11111
    } opcode_e;

    // One instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            opcode_e                 opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rd;    // Bits 7..5
            logic [4:0]              imm;
        } iFmt1;
        struct packed {
            opcode_e                 opcode;
            logic [regAddrWidth-1:0] rs;
            logic [7:0]              imm;
        } iFmt2;
        struct packed {
            opcode_e                 opcode;
            logic [regAddrWidth-1:0] rs;
            logic [regAddrWidth-1:0] rt;    // Shares bits with I-format rd
            logic [regAddrWidth-1:0] rd;    // Bits 4..2
            logic [1:0]              func;
        } rFmt;
        struct packed {
            opcode_e                 opcode;
            logic [10:0]             disp;
        } jFmt;
    } instrWord_t;

    // Register written back
    typedef enum logic [1:0] {
        destRdI = 2'b00,    // I-format rd
        destRdR = 2'b01,    // R-format rd
        destRs  = 2'b10,    // LBI, SLBI and STU target rs
        destR7  = 2'b11     // Link register
    } destSel_e;

    // Extension choice as {sign, size} with size 00 for 5, 01 for 8, 10 for 11 bits
    typedef enum logic [2:0] {
        immZero5  = 3'b000,
        immZero8  = 3'b001,
        immSign5  = 3'b100,
        immSign8  = 3'b101,
        immSign11 = 3'b110
    } immSel_e;

    // ALU operation keeps the opcode value and R-format ops are folded onto their I-format twins
    typedef enum logic [4:0] {
        aluNop  = 5'b00001, // Defined idle value
        aluAdd  = 5'b01000, aluSub  = 5'b01001, aluXor  = 5'b01010, aluAndn = 5'b01011,
        aluSlbi = 5'b10010,
        aluRol  = 5'b10100, aluSll  = 5'b10101, aluRor  = 5'b10110, aluSrl  = 5'b10111,
        aluLbi  = 5'b11000, aluBtr  = 5'b11001,
        aluSeq  = 5'b11100, aluSlt  = 5'b11101, aluSle  = 5'b11110, aluSco  = 5'b11111
    } aluOp_e;

endpackage

`default_nettype wire

/* common/ctrlIf.sv */
// Decoded control word for one instruction and only valid in the cycle the instruction is fetched
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf import cpuPkg::*; ();

    logic     regWrite;     // Register file write request
    destSel_e destSel;      // Which register receives write-back
    immSel_e  immSel;       // Field and extension of the immediate
    logic     aluSrcImm;    // Operand B from immediate instead of rt
    aluOp_e   aluOp;
    logic     memEnable;    // Data memory access
    logic     memWr;        // Access is a store
    logic     memToReg;     // Load data is written back
    logic     pcToReg;      // PC+2 is written back for links
    logic     branchTaken;  // PC+2 plus displacement
    logic     regJump;      // rs plus immediate
    logic     halt;

    modport decode (
        output regWrite, destSel, immSel, aluSrcImm, aluOp, memEnable, memWr,
               memToReg, pcToReg, branchTaken, regJump, halt
    );

    modport datapath (
        input regWrite, destSel, immSel, aluSrcImm, aluOp, memEnable, memWr,
              memToReg, pcToReg, branchTaken, regJump, halt
    );

endinterface

`default_nettype wire

/* design/decode/controlDecoder.sv */
// Purely combinational opcode decoder where branch flags must describe rs of the same word and SIIC or RTI only raise err
`timescale 1ns/1ps
`default_nettype none

module controlDecoder import cpuPkg::*; (
    input  instrWord_t     instr,
    input  logic           zeroFlag,    // rs == 0
    input  logic           signFlag,    // rs < 0
    ctrlIf.decode          ctrl,
    output logic           err
);

    opcode_e opcode;

    assign opcode = instr.rFmt.opcode;  // Same bits in every view

    always_comb begin
        // Safe idle word unless an opcode below says otherwise
        ctrl.regWrite    = 1'b0;
        ctrl.destSel     = destRdI;
        ctrl.immSel      = immSign5;
        ctrl.aluSrcImm   = 1'b0;
        ctrl.aluOp       = aluNop;
        ctrl.memEnable   = 1'b0;
        ctrl.memWr       = 1'b0;
        ctrl.memToReg    = 1'b0;
        ctrl.pcToReg     = 1'b0;
        ctrl.branchTaken = 1'b0;
        ctrl.regJump     = 1'b0;
        ctrl.halt        = 1'b0;
        err              = 1'b0;

        case (opcode)
            // Special ops
            opHalt: ctrl.halt = 1'b1;           // Stops PC after this retire
            opNop:  ;
            opSiic, opRti: err = 1'b1;          // No exception support so these act as NOP

            // I-format 1 ALU ops
            opAddi, opSubi, opXori, opAndni, opRoli, opSlli, opRori, opSrli: begin
                ctrl.regWrite  = 1'b1;
                ctrl.destSel   = destRdI;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluOp_e'(opcode);
                // Opcode bit 1 picks zero extension for logic ops and right shifts
                ctrl.immSel    = instr.iFmt1.opcode[1] ? immZero5 : immSign5;
            end

            // Memory ops address rs plus sign-extended imm5
            opSt, opLd, opStu: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluAdd;
                ctrl.immSel    = immSign5;
                ctrl.memEnable = 1'b1;
                if (opcode == opLd) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.destSel  = destRdI;
                end else begin
                    ctrl.memWr = 1'b1;
                end
                if (opcode == opStu) begin
                    ctrl.regWrite = 1'b1;       // Address goes back to rs
                    ctrl.destSel  = destRs;
                end
            end

            // R-format ops
            opBtr, opArith, opShift, opSeq, opSlt, opSle, opSco: begin
                ctrl.regWrite = 1'b1;
                ctrl.destSel  = destRdR;
                if (opcode == opArith) begin
                    ctrl.aluOp = aluOp_e'({3'b010, instr.rFmt.func});  // ADD SUB XOR ANDN
                end else if (opcode == opShift) begin
                    ctrl.aluOp = aluOp_e'({3'b101, instr.rFmt.func});  // ROL SLL ROR SRL
                end else begin
                    ctrl.aluOp = aluOp_e'(opcode);
                end
            end

            // I-format 2 conditional branches on rs
            opBeqz, opBnez, opBltz, opBgez: begin
                ctrl.immSel = immSign8;
                case (opcode)
                    opBeqz:  ctrl.branchTaken = zeroFlag;
                    opBnez:  ctrl.branchTaken = ~zeroFlag;
                    opBltz:  ctrl.branchTaken = signFlag;
                    default: ctrl.branchTaken = ~signFlag;  // BGEZ
                endcase
            end

            // Constant builders write rs
            opLbi, opSlbi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.destSel   = destRs;
                ctrl.aluSrcImm = 1'b1;
                ctrl.immSel    = (opcode == opLbi) ? immSign8 : immZero8;
                ctrl.aluOp     = (opcode == opLbi) ? aluLbi : aluSlbi;
            end

            // Jumps with optional link to R7
            opJ, opJal, opJr, opJalr: begin
                if (opcode == opJ || opcode == opJal) begin
                    ctrl.immSel      = immSign11;
                    ctrl.branchTaken = 1'b1;
                end else begin
                    ctrl.immSel  = immSign8;
                    ctrl.regJump = 1'b1;
                end
                if (opcode == opJal || opcode == opJalr) begin
                    ctrl.regWrite = 1'b1;       // No memory access on links
                    ctrl.destSel  = destR7;
                    ctrl.pcToReg  = 1'b1;
                end
            end

            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* design/decode/immExtend.sv */
// Combinational immediate extender and an unknown extension choice yields zero
`timescale 1ns/1ps
`default_nettype none

module immExtend import cpuPkg::*; (
    input  instrWord_t            instr,
    input  immSel_e               immSel,
    output logic [dataWidth-1:0]  imm
);

    always_comb begin
        case (immSel)
            immZero5:  imm = {11'b0, instr.iFmt1.imm};
            immSign5:  imm = {{11{instr.iFmt1.imm[4]}}, instr.iFmt1.imm};
            immZero8:  imm = {8'b0, instr.iFmt2.imm};
            immSign8:  imm = {{8{instr.iFmt2.imm[7]}}, instr.iFmt2.imm};
            immSign11: imm = {{5{instr.jFmt.disp[10]}}, instr.jFmt.disp};   // Jump displacement
            default:   imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/regFile.sv */
// Eight-entry register file with no write-to-read bypass so a read sees the value before the edge
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rdAddrA,
    input  logic [regAddrWidth-1:0] rdAddrB,
    output logic [dataWidth-1:0]    rdDataA,
    output logic [dataWidth-1:0]    rdDataB,
    input  logic                    wrEn,
    input  logic [regAddrWidth-1:0] wrAddr,
    input  logic [dataWidth-1:0]    wrData
);

    localparam int regCount = 1 << regAddrWidth;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;      // Program starts from all-zero registers
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    assign rdDataA = regs[rdAddrA];     // rs port
    assign rdDataB = regs[rdAddrB];     // rt or store data port

endmodule

`default_nettype wire

/* design/alu.sv */
// Combinational ALU where shifts use only opB bits 3..0 and the flags always describe opA
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
    input  logic [dataWidth-1:0] opA,       // rs
    input  logic [dataWidth-1:0] opB,       // rt or immediate
    input  aluOp_e               aluOp,
    output logic [dataWidth-1:0] result,
    output logic                 zeroFlag,
    output logic                 signFlag
);

    logic [dataWidth:0]       sum;          // Extra bit holds carry-out
    logic [3:0]               shamt;
    logic [2*dataWidth-1:0]   rolWide;
    logic [2*dataWidth-1:0]   rorWide;
    logic [dataWidth-1:0]     reversed;
    logic                     isEqual;
    logic                     isLess;

    assign sum     = {1'b0, opA} + {1'b0, opB};
    assign shamt   = opB[3:0];
    assign rolWide = {opA, opA} << shamt;   // Upper half is the rotated word
    assign rorWide = {opA, opA} >> shamt;   // Lower half is the rotated word
    assign isEqual = (opA == opB);
    assign isLess  = ($signed(opA) < $signed(opB));

    always_comb begin
        for (int i = 0; i < dataWidth; i++) begin
            reversed[i] = opA[dataWidth-1-i];
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd:  result = sum[dataWidth-1:0];
            aluSub:  result = opB - opA;                    // ISA subtracts rs from the other operand
            aluXor:  result = opA ^ opB;
            aluAndn: result = opA & ~opB;
            aluRol:  result = rolWide[2*dataWidth-1:dataWidth];
            aluSll:  result = opA << shamt;
            aluRor:  result = rorWide[dataWidth-1:0];
            aluSrl:  result = opA >> shamt;                 // Logical
            aluSeq:  result = {{(dataWidth-1){1'b0}}, isEqual};
            aluSlt:  result = {{(dataWidth-1){1'b0}}, isLess};
            aluSle:  result = {{(dataWidth-1){1'b0}}, isLess | isEqual};
            aluSco:  result = {{(dataWidth-1){1'b0}}, sum[dataWidth]};
            aluBtr:  result = reversed;
            aluLbi:  result = opB;                          // Already sign extended
            aluSlbi: result = {opA[7:0], 8'b0} | opB;
            default: result = '0;                           // NOP and unused codes
        endcase
    end

    // Branch conditions on rs
    assign zeroFlag = (opA == '0);
    assign signFlag = opA[dataWidth-1];

endmodule

`default_nettype wire

/* design/pcUnit.sv */
// PC register and halt latch where only reset leaves the halted state
`timescale 1ns/1ps
`default_nettype none

module pcUnit import cpuPkg::*; #(
    parameter logic [dataWidth-1:0] resetPc = '0
) (
    input  logic                  clk,
    input  logic                  arstN,
    ctrlIf.datapath               ctrl,
    input  logic [dataWidth-1:0]  imm,
    input  logic [dataWidth-1:0]  rsValue,
    output logic [dataWidth-1:0]  pc,
    output logic [dataWidth-1:0]  pcPlus2,
    output logic                  halted      // Also masks the datapath write strobes
);

    logic [dataWidth-1:0] nextPc;

    assign pcPlus2 = pc + dataWidth'(2);

    always_comb begin
        if (ctrl.regJump) begin
            nextPc = rsValue + imm;             // JR and JALR
        end else if (ctrl.branchTaken) begin
            nextPc = pcPlus2 + imm;             // Taken branch and J or JAL
        end else begin
            nextPc = pcPlus2;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc     <= resetPc;
            halted <= 1'b0;
        end else if (!halted) begin
            pc     <= nextPc;                   // HALT itself still steps to PC+2
            halted <= ctrl.halt;
        end
    end

endmodule

`default_nettype wire

/* design/cpuTop.sv */
// Single-cycle core where both memories must answer combinationally within the cycle of the request
`timescale 1ns/1ps
`default_nettype none

module cpuTop import cpuPkg::*; #(
    parameter logic [dataWidth-1:0] resetPc = '0
) (
    input  logic                  clk,
    input  logic                  arstN,
    output logic [dataWidth-1:0]  instrAddr,
    input  logic [dataWidth-1:0]  instr,
    output logic                  memEnable,
    output logic                  memWr,
    output logic [dataWidth-1:0]  memAddr,
    output logic [dataWidth-1:0]  memWrData,
    input  logic [dataWidth-1:0]  memRdData,
    output logic                  halted,
    output logic                  err
);

    instrWord_t              instrWord;
    logic                    zeroFlag;
    logic                    signFlag;
    logic [dataWidth-1:0]    imm;
    logic [dataWidth-1:0]    rdDataA;
    logic [dataWidth-1:0]    rdDataB;
    logic [dataWidth-1:0]    opB;
    logic [dataWidth-1:0]    aluResult;
    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    pcPlus2;
    logic [dataWidth-1:0]    wbData;
    logic [regAddrWidth-1:0] wrAddr;
    logic                    regWe;

    ctrlIf ctrlBus ();

    assign instrWord = instr;
    assign instrAddr = pc;

    controlDecoder uDecoder (
        .instr    (instrWord),
        .zeroFlag (zeroFlag),
        .signFlag (signFlag),
        .ctrl     (ctrlBus.decode),
        .err      (err)
    );

    immExtend uImm (
        .instr  (instrWord),
        .immSel (ctrlBus.immSel),
        .imm    (imm)
    );

    // Destination register index
    always_comb begin
        case (ctrlBus.destSel)
            destRdI: wrAddr = instrWord.iFmt1.rd;
            destRdR: wrAddr = instrWord.rFmt.rd;
            destRs:  wrAddr = instrWord.iFmt1.rs;
            default: wrAddr = regAddrWidth'(7);     // R7 link
        endcase
    end

    assign wbData = ctrlBus.pcToReg  ? pcPlus2   :
                    ctrlBus.memToReg ? memRdData : aluResult;

    assign regWe = ctrlBus.regWrite & ~halted;

    regFile uRegs (
        .clk     (clk),
        .arstN   (arstN),
        .rdAddrA (instrWord.rFmt.rs),
        .rdAddrB (instrWord.rFmt.rt),   // Also I-format rd for store data
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (regWe),
        .wrAddr  (wrAddr),
        .wrData  (wbData)
    );

    assign opB = ctrlBus.aluSrcImm ? imm : rdDataB;

    alu uAlu (
        .opA      (rdDataA),
        .opB      (opB),
        .aluOp    (ctrlBus.aluOp),
        .result   (aluResult),
        .zeroFlag (zeroFlag),
        .signFlag (signFlag)
    );

    pcUnit #(.resetPc(resetPc)) uPc (
        .clk     (clk),
        .arstN   (arstN),
        .ctrl    (ctrlBus.datapath),
        .imm     (imm),
        .rsValue (rdDataA),
        .pc      (pc),
        .pcPlus2 (pcPlus2),
        .halted  (halted)
    );

    // Data memory side and nothing leaves once halted
    assign memEnable = ctrlBus.memEnable & ~halted;
    assign memWr     = ctrlBus.memWr & ~halted;
    assign memAddr   = aluResult;                   // rs plus imm5
    assign memWrData = rdDataB;

endmodule

`default_nettype wire

/* verif/clockGen.sv */
// Free-running 4 ns clock and an active-low reset held for the first 10 rising edges
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (10) @(posedge clk);
        #0.5 arstN = 1'b1;                  // Release just after an edge
    end

endmodule

`default_nettype wire

/* verif/cpuTb.sv */
// Runs the program from verif/cpuPatterns.hex from the project root and compares every store with the log
`timescale 1ns/1ps
`default_nettype none

module cpuTb;

    localparam int timeoutCycles = 2000;
    localparam int logBase       = 8'h80;   // Store log as address/data pairs
    localparam int dataBase      = 8'h40;   // Initial data memory image

    logic        clk;
    logic        arstN;
    logic [15:0] instrAddr;
    logic [15:0] instr;
    logic        memEnable;
    logic        memWr;
    logic [15:0] memAddr;
    logic [15:0] memWrData;
    logic [15:0] memRdData;
    logic        halted;
    logic        err;

    logic [15:0] pat  [0:255];              // Whole pattern file
    logic [15:0] dmem [0:127];
    int          storeIdx;                  // Next expected log pair
    int          expStores;
    int          errCount;
    logic        pendWr;
    logic [15:0] pendAddr;
    logic [15:0] pendData;

    clockGen uClk (
        .clk   (clk),
        .arstN (arstN)
    );

    cpuTop #(.resetPc(16'h0000)) dut (
        .clk       (clk),
        .arstN     (arstN),
        .instrAddr (instrAddr),
        .instr     (instr),
        .memEnable (memEnable),
        .memWr     (memWr),
        .memAddr   (memAddr),
        .memWrData (memWrData),
        .memRdData (memRdData),
        .halted    (halted),
        .err       (err)
    );

    // Both memories answer in the same cycle
    assign instr     = (instrAddr[15:7] == '0) ? pat[instrAddr[6:1]] : 16'h0000;
    assign memRdData = (memAddr[15:8] == '0) ? dmem[memAddr[7:1]] : 16'h0000;

    task automatic checkValue(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // LD, ST and STU reach the data port
    function automatic logic accessesMemory(input logic [4:0] op);
        return op == 5'b10000 || op == 5'b10001 || op == 5'b10011;
    endfunction

    // Only ST and STU write
    function automatic logic writesMemory(input logic [4:0] op);
        return op == 5'b10000 || op == 5'b10011;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            pat[i] = 16'h0000;              // Unlisted program words decode as HALT
        end
        $readmemh("verif/cpuPatterns.hex", pat);
        for (int i = 0; i < 128; i++) begin
            dmem[i] = (i < 16) ? pat[dataBase + i] : (16'(i) << 1) ^ 16'hA5A5;
        end
        expStores = 0;
        while (expStores < 56 && pat[logBase + 2 * expStores] !== 16'hFFFF) begin
            expStores++;
        end
    end

    // Sample strobes mid-cycle where the combinational outputs have settled
    always @(negedge clk) begin
        pendWr <= 1'b0;
        if (arstN) begin
            checkValue("memEnable", {15'b0, memEnable},
                       {15'b0, !halted && accessesMemory(instr[15:11])});
            checkValue("memWr", {15'b0, memWr},
                       {15'b0, !halted && writesMemory(instr[15:11])});
        end
        if (arstN && !halted && memEnable && memWr) begin
            if (storeIdx >= expStores) begin
                abortRun("More stores than the log expects");
            end else begin
                checkValue("memAddr", memAddr, pat[logBase + 2 * storeIdx]);
                checkValue("memWrData", memWrData, pat[logBase + 2 * storeIdx + 1]);
                storeIdx <= storeIdx + 1;
                pendWr   <= 1'b1;
                pendAddr <= memAddr;
                pendData <= memWrData;
            end
        end
        if (arstN && !halted && err) begin
            errCount <= errCount + 1;
        end
    end

    always @(posedge clk) begin
        if (pendWr && pendAddr[15:8] == '0) begin
            dmem[pendAddr[7:1]] <= pendData;    // Store lands at the closing edge
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'h86ea));
        storeIdx   = 0;
        errCount   = 0;
        pendWr     = 1'b0;
        pendAddr   = '0;
        pendData   = '0;

        cycles = 0;
        while (!arstN) begin
            @(posedge clk);
            cycles++;
            if (cycles > 100) begin
                abortRun("Reset was never released");
            end
        end

        cycles = 0;
        while (halted !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > timeoutCycles) begin
                abortRun("Timeout waiting for the core to halt");
            end
        end

        @(negedge clk);
        checkValue("instrAddr", instrAddr, pat[8'hF0] + 16'h0002);
        repeat (20) @(negedge clk);
        checkValue("halted", {15'b0, halted}, 16'h0001);
        checkValue("instrAddr", instrAddr, pat[8'hF0] + 16'h0002);   // PC frozen

        if (storeIdx != expStores) begin
            abortRun("Fewer stores than the log expects");
        end else if (errCount != int'(pat[8'hF1])) begin
            abortRun("err asserted a wrong number of times");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verif/cpuPatterns.hex */
// Program words at 00, data memory words at 40, store log address/data pairs at 80 ending in FFFF
// Expected halt byte address at F0 and expected err count at F1
@00
C640 C112 9134 9E22 415D 9E42 4965 9E62
519F 9E82 59B4 9EA2 A144 9E42 B963 9E62
D170 9E82 D175 9EA2 ED28 9E42 F98C 9E62
C910 9E82 88AC 9EA2 80CE 6002 9E22 6802
9E42 7502 9E22 7D02 3002 9E22 9EE2 C454
3C00 9E22 9EE2 C45A 2C02 9E22 2002 9E22
1000 1800 0800 9EA2 0000 9E22
@40
0000 1111 2222 3333 4444 5555 BEEF 7777
8888 9999 AAAA BBBB CCCC DDDD EEEE 0F0F
@80
0042 1234
0044 1231
0046 EDD1
0048 122B
004A 1220
004C 2341
004E 0246
0050 147A
0052 F012
0054 0001
0056 0000
0058 2C48
005A BEEF
000E 005A
005C 0001
005E 004A
0060 0052
0062 BEEF
FFFF FFFF
@F0
0068 0002

/* list.f */
common/cpuPkg.sv
common/ctrlIf.sv
design/decode/controlDecoder.sv
design/decode/immExtend.sv
design/regFile.sv
design/alu.sv
design/pcUnit.sv
design/cpuTop.sv
verif/clockGen.sv
verif/cpuTb.sv

/* Makefile */
TOP = cpuTb

all: run

build:
	verilator --binary -f list.f --top-module $(TOP) -o $(TOP)

run: build
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

lint:
	verilator --lint-only --timing -Wall -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
